// ==== bench/dither_model.svh ====
`ifndef DITHER_MODEL_SVH
`define DITHER_MODEL_SVH

// pixel pattern of a test frame
typedef enum logic [2:0] {
    PAT_ZERO,
    PAT_FULL,
    PAT_RAMP,
    PAT_RANDOM,
    PAT_MID
} pattern_t;

// one row of the stimulus table
// fill_check set means every byte read back must equal fill_value
typedef struct packed {
    logic [7:0] width;
    logic [7:0] height;
    pattern_t   pattern;
    logic       fill_check;
    logic [7:0] fill_value;
} frame_spec_t;

localparam int NUM_FRAMES = 12;

// flat frames, small ramps, full size and the single row and column cases
localparam frame_spec_t FRAME_TABLE [NUM_FRAMES] = '{
    '{8'd4,  8'd4,  PAT_ZERO,   1'b1, 8'h00},
    '{8'd4,  8'd4,  PAT_FULL,   1'b1, 8'hff},
    '{8'd4,  8'd4,  PAT_RAMP,   1'b0, 8'h00},
    '{8'd4,  8'd4,  PAT_RANDOM, 1'b0, 8'h00},
    '{8'd16, 8'd16, PAT_RANDOM, 1'b0, 8'h00},
    '{8'd16, 8'd16, PAT_RAMP,   1'b0, 8'h00},
    '{8'd1,  8'd8,  PAT_RANDOM, 1'b0, 8'h00},
    '{8'd8,  8'd1,  PAT_RANDOM, 1'b0, 8'h00},
    '{8'd1,  8'd8,  PAT_RAMP,   1'b0, 8'h00},
    '{8'd8,  8'd1,  PAT_RAMP,   1'b0, 8'h00},
    '{8'd5,  8'd3,  PAT_MID,    1'b0, 8'h00},
    '{8'd3,  8'd5,  PAT_RANDOM, 1'b0, 8'h00}
};

// frame as sent, and the expected dithered frame
pixel_t image_in  [MAX_DIM*MAX_DIM];
pixel_t image_ref [MAX_DIM*MAX_DIM];

// add weight sixteenths of the error, wraps at 256
task automatic spread_error(input int index, input int err, input int weight);
    image_ref[index] = 8'((int'(image_ref[index]) + ((err * weight) >> 4)) & 255);
endtask

// raster order floyd-steinberg, neighbours outside the image skipped
task automatic run_reference(input int width, input int height);
    int row;
    int col;
    int index;
    int old_val;
    int new_val;
    int err;
    for (index = 0; index < width * height; index++) begin
        image_ref[index] = image_in[index];
    end
    for (row = 0; row < height; row++) begin
        for (col = 0; col < width; col++) begin
            index   = row * width + col;
            old_val = int'(image_ref[index]);
            new_val = (old_val >= 128) ? 255 : 0;
            // old minus new, modulo 256
            err     = (old_val - new_val) & 255;
            image_ref[index] = 8'(new_val);
            if (col + 1 < width) begin
                spread_error(index + 1, err, 7);
            end
            if (row + 1 < height && col > 0) begin
                spread_error(index + width - 1, err, 3);
            end
            if (row + 1 < height) begin
                spread_error(index + width, err, 5);
            end
            if (row + 1 < height && col + 1 < width) begin
                spread_error(index + width + 1, err, 1);
            end
        end
    end
endtask

`endif

// ==== bench/tb_dither_spi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dither_spi;
    import dither_pkg::*;

    localparam int          RESET_CYCLES = 10;
    localparam int          IDLE_CYCLES  = 20;
    localparam logic [31:0] SEED         = 32'h24f84cb0;

    logic SPI_CLK;
    logic rst;
    logic SPI_CS;
    logic SPI_MOSI;
    logic SPI_MISO;
    logic frame_ready;

    `include "dither_model.svh"

    int          cycle_count;
    int          cycle_limit;
    int          fail_count;
    int          pixel_count;
    int          f;
    int          i;
    frame_spec_t spec;
    pixel_t      readback [MAX_DIM*MAX_DIM];

    dither_spi_top DUT (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .SPI_CS      (SPI_CS),
        .SPI_MOSI    (SPI_MOSI),
        .SPI_MISO    (SPI_MISO),
        .frame_ready (frame_ready)
    );

    // 20 ns period
    always #10 SPI_CLK = ~SPI_CLK;

    // watchdog against a stuck handshake
    always @(posedge SPI_CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("=== FAIL ===");
            $display("timeout: no result after %0d clock cycles", cycle_count);
            $fatal(1, "run did not finish in time");
        end
    end

    task automatic report_failure(input string msg);
        fail_count++;
        $display("=== FAIL ===");
        $display("%s", msg);
        $fatal(1, "check failed");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            report_failure($sformatf("Error: time %0t %s expected %0d actual %0d",
                                     $time, name, expected, actual));
        end
    endtask

    // ramp spans 0..255 across the frame
    // random pixels come from the seeded stream
    function automatic pixel_t pattern_pixel(input pattern_t kind, input int index,
                                             input int count);
        case (kind)
            PAT_ZERO: return 8'h00;
            PAT_FULL: return 8'hff;
            PAT_RAMP: return 8'((index * 255) / ((count > 1) ? count - 1 : 1));
            PAT_MID:  return 8'd127;
            default:  return 8'($urandom);
        endcase
    endfunction

    // msb first, one bit per falling edge
    task automatic send_byte(input logic [7:0] value);
        int b;
        for (b = 7; b >= 0; b--) begin
            @(negedge SPI_CLK);
            SPI_CS   = 1'b0;
            SPI_MOSI = value[b];
        end
    endtask

    task automatic send_frame(input logic [7:0] width, input logic [7:0] height,
                              input int count);
        int n;
        send_byte(width);
        send_byte(height);
        for (n = 0; n < count; n++) begin
            send_byte(image_in[n]);
        end
        @(negedge SPI_CLK);
        SPI_CS   = 1'b1;
        SPI_MOSI = 1'b0;
    endtask

    // miso sampled mid-cycle
    // the rising edge after each sample shifts the next bit out
    task automatic receive_frame(input int count);
        int         n;
        int         b;
        logic [7:0] value;
        for (n = 0; n < count; n++) begin
            for (b = 7; b >= 0; b--) begin
                @(negedge SPI_CLK);
                SPI_CS   = 1'b0;
                value[b] = SPI_MISO;
            end
            readback[n] = value;
        end
        @(negedge SPI_CLK);
        SPI_CS = 1'b1;
    endtask

    initial begin
        SPI_CLK     = 1'b0;
        rst         = 1'b1;
        SPI_CS      = 1'b1;
        SPI_MOSI    = 1'b0;
        cycle_count = 0;
        fail_count  = 0;
        void'($urandom(SEED));

        // per frame budget covers header, load and readout bits, processing and margin
        cycle_limit = RESET_CYCLES + IDLE_CYCLES;
        for (f = 0; f < NUM_FRAMES; f++) begin
            pixel_count = int'(FRAME_TABLE[f].width) * int'(FRAME_TABLE[f].height);
            cycle_limit += 16 + 16 * pixel_count + 12 * pixel_count + 100;
        end

        repeat (RESET_CYCLES) @(negedge SPI_CLK);
        rst = 1'b0;

        // nothing loaded yet so outputs stay quiet
        repeat (IDLE_CYCLES) begin
            @(negedge SPI_CLK);
            check_value("frame_ready", 0, frame_ready);
            check_value("SPI_MISO", 0, SPI_MISO);
        end

        for (f = 0; f < NUM_FRAMES; f++) begin
            spec        = FRAME_TABLE[f];
            pixel_count = int'(spec.width) * int'(spec.height);
            for (i = 0; i < pixel_count; i++) begin
                image_in[i] = pattern_pixel(spec.pattern, i, pixel_count);
            end
            run_reference(int'(spec.width), int'(spec.height));

            check_value("frame_ready", 0, frame_ready);
            send_frame(spec.width, spec.height, pixel_count);
            // watchdog bounds this wait
            while (frame_ready !== 1'b1) begin
                @(negedge SPI_CLK);
            end
            receive_frame(pixel_count);
            // back in load once the last byte is out
            @(negedge SPI_CLK);
            check_value("frame_ready", 0, frame_ready);

            for (i = 0; i < pixel_count; i++) begin
                assert (readback[i] == 8'h00 || readback[i] == 8'hff) else begin
                    report_failure($sformatf(
                        "Error: time %0t SPI_MISO byte %0d of frame %0d expected %s actual %0d",
                        $time, i, f, "0 or 255", readback[i]));
                end
                if (spec.fill_check) begin
                    check_value($sformatf("SPI_MISO byte %0d of frame %0d", i, f),
                                spec.fill_value, readback[i]);
                end
                check_value($sformatf("SPI_MISO byte %0d of frame %0d", i, f),
                            image_ref[i], readback[i]);
            end
        end

        if (fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== dither_spi.f ====
+incdir+bench
source/dither_pkg.sv
source/spi_pixel_rx.sv
source/frame_buffer.sv
source/dither_engine.sv
source/spi_pixel_tx.sv
source/dither_spi_top.sv
bench/tb_dither_spi.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dither testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f dither_spi.f \
    --top-module tb_dither_spi -o sim_dither
./obj_dir/sim_dither 2>&1 | tee sim.log
if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== source/dither_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dither_engine (
    input  logic                    SPI_CLK,
    input  logic                    rst,
    input  dither_pkg::phase_t      phase,
    input  dither_pkg::frame_dims_t dims,
    input  dither_pkg::pixel_t      rd_data,
    output dither_pkg::mem_wr_t     eng_wr,
    output dither_pkg::mem_rd_t     eng_rd,
    output logic                    process_done
);
    import dither_pkg::*;

    // each state writes the value read in the one before
    // and reads the next neighbour in the same cycle
    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_QUANT,
        S_EAST,
        S_SWEST,
        S_SOUTH,
        S_SEAST,
        S_DONE
    } eng_state_t;

    eng_state_t       state;
    addr_t            idx;
    logic [DIM_W-1:0] col;
    logic [DIM_W-1:0] row;
    pixel_t           err;
    pixel_t           quant;
    logic             first_col;
    logic             last_col;
    logic             last_row;
    logic             last_pix;
    logic             e_ok;
    logic             sw_ok;
    logic             s_ok;
    logic             se_ok;
    addr_t            addr_e;
    addr_t            addr_sw;
    addr_t            addr_s;
    addr_t            addr_se;
    logic [3:0]       weight;
    logic [11:0]      spread;
    pixel_t           updated;

    // black or white
    assign quant = (rd_data >= THRESHOLD) ? {PIXEL_W{1'b1}} : '0;

    // image edges
    assign first_col = (col == '0);
    assign last_col  = (col == dims.width - 1'b1);
    assign last_row  = (row == dims.height - 1'b1);
    assign last_pix  = ({1'b0, idx} == dims.pixel_count - 1'b1);

    // neighbours inside the image
    assign e_ok  = !last_col;
    assign sw_ok = !last_row && !first_col;
    assign s_ok  = !last_row;
    assign se_ok = !last_row && !last_col;

    assign addr_e  = idx + 1'b1;
    assign addr_s  = idx + addr_t'(dims.width);
    assign addr_sw = addr_s - 1'b1;
    assign addr_se = addr_s + 1'b1;

    // weight of the neighbour whose value is on rd_data now
    always_comb begin
        case (state)
            S_EAST:  weight = WEIGHT_E;
            S_SWEST: weight = WEIGHT_SW;
            S_SOUTH: weight = WEIGHT_S;
            default: weight = WEIGHT_SE;
        endcase
    end

    // full width product then divide by 16, sum wraps at 256
    assign spread  = 12'(err) * 12'(weight);
    assign updated = rd_data + spread[11:4];

    always_comb begin
        eng_wr = '0;
        eng_rd = '0;
        case (state)
            S_FETCH: begin
                eng_rd.en   = 1'b1;
                eng_rd.addr = idx;
            end
            S_QUANT: begin
                eng_wr.en   = 1'b1;
                eng_wr.addr = idx;
                eng_wr.data = quant;
                eng_rd.en   = e_ok;
                eng_rd.addr = addr_e;
            end
            S_EAST: begin
                eng_wr.en   = e_ok;
                eng_wr.addr = addr_e;
                eng_wr.data = updated;
                eng_rd.en   = sw_ok;
                eng_rd.addr = addr_sw;
            end
            S_SWEST: begin
                eng_wr.en   = sw_ok;
                eng_wr.addr = addr_sw;
                eng_wr.data = updated;
                eng_rd.en   = s_ok;
                eng_rd.addr = addr_s;
            end
            S_SOUTH: begin
                eng_wr.en   = s_ok;
                eng_wr.addr = addr_s;
                eng_wr.data = updated;
                eng_rd.en   = se_ok;
                eng_rd.addr = addr_se;
            end
            S_SEAST: begin
                eng_wr.en   = se_ok;
                eng_wr.addr = addr_se;
                eng_wr.data = updated;
                // next pixel, or byte 0 so tx finds it on rd_data at readout
                eng_rd.en   = 1'b1;
                eng_rd.addr = last_pix ? '0 : addr_e;
            end
            default: begin
                eng_wr = '0;
                eng_rd = '0;
            end
        endcase
    end

    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            idx   <= '0;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    idx <= '0;
                    col <= '0;
                    row <= '0;
                    if (phase == PH_PROCESS) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_QUANT;
                S_QUANT: state <= S_EAST;
                S_EAST:  state <= S_SWEST;
                S_SWEST: state <= S_SOUTH;
                S_SOUTH: state <= S_SEAST;
                S_SEAST: begin
                    if (last_pix) begin
                        state <= S_DONE;
                    end else begin
                        // next pixel already read this cycle
                        state <= S_QUANT;
                        idx   <= idx + 1'b1;
                        if (last_col) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // old minus new, modulo 256
    always_ff @(posedge SPI_CLK) begin
        if (state == S_QUANT) begin
            err <= rd_data - quant;
        end
    end

    assign process_done = (state == S_DONE);

    // diffusion never lands past the loaded frame
    assert property (@(posedge SPI_CLK) disable iff (rst)
        eng_wr.en |-> ({1'b0, eng_wr.addr} < dims.pixel_count));

endmodule

`default_nettype wire

// ==== source/dither_pkg.sv ====
`default_nettype none

package dither_pkg;

    // image limits
    localparam int MAX_DIM   = 16;
    localparam int ADDR_W    = $clog2(MAX_DIM * MAX_DIM);
    localparam int PIXEL_W   = 8;
    // counts the eight bits of a byte
    localparam int BIT_CNT_W = 3;
    // holds 1 to MAX_DIM
    localparam int DIM_W     = $clog2(MAX_DIM + 1);

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    // frame header as captured by rx
    // pixel_count is one bit wider than an address to hold MAX_DIM squared
    typedef struct packed {
        logic [DIM_W-1:0] width;
        logic [DIM_W-1:0] height;
        logic [ADDR_W:0]  pixel_count;
    } frame_dims_t;

    // one write port request
    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t data;
    } mem_wr_t;

    // one read port request
    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_t;

    // memory owner follows the phase
    typedef enum logic [1:0] {
        PH_LOAD,
        PH_PROCESS,
        PH_READOUT
    } phase_t;

    // error diffusion weights in sixteenths
    localparam logic [3:0] WEIGHT_E  = 4'd7;
    localparam logic [3:0] WEIGHT_SW = 4'd3;
    localparam logic [3:0] WEIGHT_S  = 4'd5;
    localparam logic [3:0] WEIGHT_SE = 4'd1;

    // at or above this a pixel goes white
    localparam pixel_t THRESHOLD = 8'd128;

endpackage

`default_nettype wire

// ==== source/dither_spi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dither_spi_top (
    input  logic SPI_CLK,
    input  logic rst,
    input  logic SPI_CS,
    input  logic SPI_MOSI,
    output logic SPI_MISO,
    output logic frame_ready
);
    import dither_pkg::*;

    // memory requests toward the buffer
    mem_wr_t     rx_wr;
    mem_wr_t     eng_wr;
    mem_rd_t     eng_rd;
    mem_rd_t     tx_rd;
    // shared frame state
    frame_dims_t dims;
    phase_t      phase;
    pixel_t      rd_data;
    // phase hand-off pulses
    logic        load_done;
    logic        process_done;
    logic        readout_done;

    spi_pixel_rx u_rx (
        .SPI_CLK   (SPI_CLK),
        .rst       (rst),
        .SPI_CS    (SPI_CS),
        .SPI_MOSI  (SPI_MOSI),
        .phase     (phase),
        .rx_wr     (rx_wr),
        .dims      (dims),
        .load_done (load_done)
    );

    frame_buffer u_buf (
        .SPI_CLK      (SPI_CLK),
        .rst          (rst),
        .rx_wr        (rx_wr),
        .eng_wr       (eng_wr),
        .eng_rd       (eng_rd),
        .tx_rd        (tx_rd),
        .load_done    (load_done),
        .process_done (process_done),
        .readout_done (readout_done),
        .rd_data      (rd_data),
        .phase        (phase),
        .frame_ready  (frame_ready)
    );

    dither_engine u_eng (
        .SPI_CLK      (SPI_CLK),
        .rst          (rst),
        .phase        (phase),
        .dims         (dims),
        .rd_data      (rd_data),
        .eng_wr       (eng_wr),
        .eng_rd       (eng_rd),
        .process_done (process_done)
    );

    spi_pixel_tx u_tx (
        .SPI_CLK      (SPI_CLK),
        .rst          (rst),
        .SPI_CS       (SPI_CS),
        .phase        (phase),
        .dims         (dims),
        .rd_data      (rd_data),
        .tx_rd        (tx_rd),
        .SPI_MISO     (SPI_MISO),
        .readout_done (readout_done)
    );

endmodule

`default_nettype wire

// ==== source/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                SPI_CLK,
    input  logic                rst,
    input  dither_pkg::mem_wr_t rx_wr,
    input  dither_pkg::mem_wr_t eng_wr,
    input  dither_pkg::mem_rd_t eng_rd,
    input  dither_pkg::mem_rd_t tx_rd,
    input  logic                load_done,
    input  logic                process_done,
    input  logic                readout_done,
    output dither_pkg::pixel_t  rd_data,
    output dither_pkg::phase_t  phase,
    output logic                frame_ready
);
    import dither_pkg::*;

    // one byte per pixel in raster order
    pixel_t  mem [MAX_DIM*MAX_DIM];
    phase_t  phase_next;
    mem_wr_t wr_req;
    mem_rd_t rd_req;

    // load then process then readout then back to load
    always_comb begin
        phase_next = phase;
        case (phase)
            PH_LOAD: begin
                if (load_done) begin
                    phase_next = PH_PROCESS;
                end
            end
            PH_PROCESS: begin
                if (process_done) begin
                    phase_next = PH_READOUT;
                end
            end
            PH_READOUT: begin
                if (readout_done) begin
                    phase_next = PH_LOAD;
                end
            end
            default: phase_next = PH_LOAD;
        endcase
    end

    // frame_ready tracks the registered phase exactly
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            phase       <= PH_LOAD;
            frame_ready <= 1'b0;
        end else begin
            phase       <= phase_next;
            frame_ready <= (phase_next == PH_READOUT);
        end
    end

    // grant the ports to this phase's owner
    always_comb begin
        wr_req = '0;
        rd_req = '0;
        case (phase)
            PH_LOAD: begin
                wr_req = rx_wr;
            end
            PH_PROCESS: begin
                wr_req = eng_wr;
                rd_req = eng_rd;
            end
            PH_READOUT: begin
                rd_req = tx_rd;
            end
            default: begin
                wr_req = '0;
                rd_req = '0;
            end
        endcase
    end

    // one write and one read per edge
    // read data lands one cycle after the request and holds until the next read
    always_ff @(posedge SPI_CLK) begin
        if (wr_req.en) begin
            mem[wr_req.addr] <= wr_req.data;
        end
        if (rd_req.en) begin
            rd_data <= mem[rd_req.addr];
        end
    end

    // each producer finishes only in its own phase
    assert property (@(posedge SPI_CLK) disable iff (rst)
        !(load_done && phase != PH_LOAD) && !(process_done && phase != PH_PROCESS)
            && !(readout_done && phase != PH_READOUT));

    // writers stay quiet outside the phase that owns the memory
    assert property (@(posedge SPI_CLK) disable iff (rst)
        !(rx_wr.en && phase != PH_LOAD) && !(eng_wr.en && phase != PH_PROCESS));

endmodule

`default_nettype wire

// ==== source/spi_pixel_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_pixel_rx (
    input  logic                    SPI_CLK,
    input  logic                    rst,
    input  logic                    SPI_CS,
    input  logic                    SPI_MOSI,
    input  dither_pkg::phase_t      phase,
    output dither_pkg::mem_wr_t     rx_wr,
    output dither_pkg::frame_dims_t dims,
    output logic                    load_done
);
    import dither_pkg::*;

    // which byte of the stream comes next
    typedef enum logic [1:0] {
        RX_WIDTH,
        RX_HEIGHT,
        RX_PIXELS
    } rx_stage_t;

    rx_stage_t            stage;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [PIXEL_W-2:0]   shift_reg;
    addr_t                wr_addr;
    logic                 bit_take;
    logic                 byte_end;
    pixel_t               rx_byte;
    logic [2*DIM_W-1:0]   area;
    logic                 last_pixel;

    // bits only count while CS is low in the load phase
    assign bit_take = !SPI_CS && (phase == PH_LOAD);
    assign byte_end = bit_take && (bit_cnt == '1);

    // full byte including the bit on the wire now
    assign rx_byte = {shift_reg, SPI_MOSI};

    // width already held when height arrives
    assign area = dims.width * rx_byte[DIM_W-1:0];
    assign last_pixel = ({1'b0, wr_addr} == dims.pixel_count - 1'b1);

    // msb first shift
    always_ff @(posedge SPI_CLK) begin
        if (bit_take) begin
            shift_reg <= rx_byte[PIXEL_W-2:0];
        end
    end

    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            stage     <= RX_WIDTH;
            bit_cnt   <= '0;
            wr_addr   <= '0;
            rx_wr     <= '0;
            dims      <= '0;
            load_done <= 1'b0;
        end else begin
            // write strobe and done are single cycle
            rx_wr.en  <= 1'b0;
            load_done <= 1'b0;
            if (bit_take) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (byte_end) begin
                case (stage)
                    RX_WIDTH: begin
                        dims.width <= rx_byte[DIM_W-1:0];
                        stage      <= RX_HEIGHT;
                    end
                    RX_HEIGHT: begin
                        dims.height      <= rx_byte[DIM_W-1:0];
                        dims.pixel_count <= area[ADDR_W:0];
                        wr_addr          <= '0;
                        stage            <= RX_PIXELS;
                    end
                    default: begin
                        rx_wr.en   <= 1'b1;
                        rx_wr.addr <= wr_addr;
                        rx_wr.data <= rx_byte;
                        wr_addr    <= wr_addr + 1'b1;
                        // last pixel hands the frame over and rearms for a header
                        if (last_pixel) begin
                            load_done <= 1'b1;
                            stage     <= RX_WIDTH;
                        end
                    end
                endcase
            end
        end
    end

    // header must describe a usable frame before pixels flow
    assert property (@(posedge SPI_CLK) disable iff (rst)
        (stage == RX_PIXELS) |-> (dims.width != '0) && (dims.height != '0)
            && (dims.width <= MAX_DIM) && (dims.height <= MAX_DIM));

endmodule

`default_nettype wire

// ==== source/spi_pixel_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_pixel_tx (
    input  logic                    SPI_CLK,
    input  logic                    rst,
    input  logic                    SPI_CS,
    input  dither_pkg::phase_t      phase,
    input  dither_pkg::frame_dims_t dims,
    input  dither_pkg::pixel_t      rd_data,
    output dither_pkg::mem_rd_t     tx_rd,
    output logic                    SPI_MISO,
    output logic                    readout_done
);
    import dither_pkg::*;

    pixel_t               shift_reg;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [ADDR_W:0]      byte_cnt;
    logic [ADDR_W:0]      next_byte;
    logic                 last_byte;
    logic                 shift_en;

    assign next_byte = byte_cnt + 1'b1;
    assign last_byte = (next_byte == dims.pixel_count);

    // stop after the final bit even if CS stays low
    assign shift_en = (phase == PH_READOUT) && !SPI_CS && !readout_done;

    // fetch at bit 6 so the byte is waiting on rd_data at bit 7
    always_comb begin
        tx_rd.en   = (bit_cnt == BIT_CNT_W'(PIXEL_W - 2)) && !last_byte;
        tx_rd.addr = next_byte[ADDR_W-1:0];
    end

    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            bit_cnt      <= '0;
            byte_cnt     <= '0;
            readout_done <= 1'b0;
        end else begin
            readout_done <= 1'b0;
            if (phase != PH_READOUT) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '1) begin
                    byte_cnt <= next_byte;
                    if (last_byte) begin
                        readout_done <= 1'b1;
                    end
                end
            end
        end
    end

    // outside readout mirror rd_data
    // engine ends on a read of byte 0 so MSB is ready at the first readout edge
    always_ff @(posedge SPI_CLK) begin
        if (phase != PH_READOUT) begin
            shift_reg <= rd_data;
        end else if (shift_en) begin
            if (bit_cnt == '1) begin
                shift_reg <= rd_data;
            end else begin
                shift_reg <= {shift_reg[PIXEL_W-2:0], 1'b0};
            end
        end
    end

    assign SPI_MISO = (phase == PH_READOUT) && shift_reg[PIXEL_W-1];

endmodule

`default_nettype wire
